//--- l1_dcache.f
+incdir+hdl
hdl/l1_dcache_pkg.sv
hdl/dcache_tag_lookup.sv
hdl/line_memory.sv
hdl/dcache_controller.sv
hdl/l1_dcache_top.sv
verification/l1_dcache_tb.sv

//--- verification/l1_dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1_dcache_macros.svh"

module l1_dcache_tb;

  localparam int CLK_PERIOD      = 10;
  localparam int NUM_SETS        = `DC_NUM_SETS;
  localparam int NUM_WAYS        = `DC_NUM_WAYS;
  localparam int OFFSET_BITS     = `DC_OFFSET_BITS;
  localparam int SET_BITS        = `DC_SET_BITS;
  localparam int TAG_BITS        = `DC_TAG_BITS;
  localparam int NUM_ACCESSES    = 2 + 5 + 6 + 6 + 200;
  localparam int ACCESS_LIMIT    = 4 * (`DC_MEM_LATENCY + 2);   // Worst miss fits well inside
  localparam int WATCHDOG_CYCLES = NUM_ACCESSES * (2 * `DC_MEM_LATENCY + 4) + 1000;

  logic                    clk;
  logic                    reset;
  logic                    cpu_req_valid;
  l1_dcache_pkg::cpu_req_t cpu_req;
  logic                    cpu_ready;
  logic                    cpu_rsp_valid;
  l1_dcache_pkg::cpu_rsp_t cpu_rsp;

  int          error_count = 0;
  int          check_count = 0;
  int          test_count  = 0;
  logic [31:0] lcg_state   = 32'h121c9fed;

  // Expected contents, absent words read as zero
  logic [31:0] ref_words [logic [31:0]];

  // Expected tag state per set and way
  bit                  m_valid [NUM_SETS][NUM_WAYS];
  int                  m_age   [NUM_SETS][NUM_WAYS];
  logic [TAG_BITS-1:0] m_tag   [NUM_SETS][NUM_WAYS];

  l1_dcache_top i_l1_dcache_top (
    .clk           (clk),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_ready     (cpu_ready),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp       (cpu_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    return ref_words.exists(addr) ? ref_words[addr] : 32'h0;
  endfunction

  // Lookup plus LRU update, returns whether the line was present
  function automatic bit predict_hit(input logic [31:0] addr);
    int                  set_i;
    int                  way;
    int                  hit_age;
    bit                  hit;
    logic [TAG_BITS-1:0] tag;
    set_i = addr[OFFSET_BITS +: SET_BITS];
    tag   = addr[31 -: TAG_BITS];
    way   = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (m_valid[set_i][w] && m_tag[set_i][w] == tag) way = w;
    hit = (way >= 0);
    if (!hit) begin
      for (int w = 0; w < NUM_WAYS; w++)
        if (!m_valid[set_i][w] && way < 0) way = w;   // First free way
      if (way < 0)
        for (int w = 0; w < NUM_WAYS; w++)
          if (m_age[set_i][w] == NUM_WAYS - 1) way = w;   // Least recently used
      m_valid[set_i][way] = 1'b1;
      m_tag[set_i][way]   = tag;
    end
    hit_age = m_age[set_i][way];
    for (int w = 0; w < NUM_WAYS; w++)
      if (m_age[set_i][w] < hit_age) m_age[set_i][w]++;
    m_age[set_i][way] = 0;
    return hit;
  endfunction

  task automatic check_rsp(input logic [31:0] addr, input l1_dcache_pkg::cpu_rsp_t got,
                           input l1_dcache_pkg::cpu_rsp_t exp);
    check_count++;
    if (got.rdata !== exp.rdata) begin
      error_count++;
      $display("mismatch at %0t: cpu_rsp.rdata got %h expected %h (addr %h)",
               $time, got.rdata, exp.rdata, addr);
    end
    if (got.hit !== exp.hit) begin
      error_count++;
      $display("mismatch at %0t: cpu_rsp.hit got %b expected %b (addr %h)",
               $time, got.hit, exp.hit, addr);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: cpu_ready got %b expected %b", $time, got, exp);
    end
  endtask

  // One request held until the cache answers
  task automatic do_access(input l1_dcache_pkg::cpu_req_t req,
                           output l1_dcache_pkg::cpu_rsp_t rsp);
    int cycles;
    cycles = 0;
    @(negedge clk);
    cpu_req_valid = 1'b1;
    cpu_req       = req;
    do begin
      @(posedge clk);   // Outputs still show the cycle before this edge
      cycles++;
      if (!cpu_rsp_valid && cycles > 1)
        check_ready(cpu_ready, 1'b0);   // Stalled in a miss
    end while (!cpu_rsp_valid && cycles < ACCESS_LIMIT);
    if (!cpu_rsp_valid) begin
      error_count++;
      $display("No response within %0d cycles for address %h", ACCESS_LIMIT, req.addr);
    end
    rsp = cpu_rsp;
    @(negedge clk);
    cpu_req_valid = 1'b0;
  endtask

  // A negative exp_hit takes the hit flag from the tag model
  task automatic access_check(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input int exp_hit);
    l1_dcache_pkg::cpu_req_t req;
    l1_dcache_pkg::cpu_rsp_t got;
    l1_dcache_pkg::cpu_rsp_t exp;
    bit                      model_hit;
    model_hit = predict_hit(addr);
    if (write) ref_words[addr] = wdata;
    exp.rdata = ref_read(addr);
    exp.hit   = (exp_hit < 0) ? model_hit : (exp_hit != 0);
    req       = '{write: write, addr: addr, wdata: wdata};
    do_access(req, got);
    check_rsp(addr, got, exp);
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("%-14s done, %0d errors", name, error_count - errors_before);
  endtask

  task automatic test_reset_read();
    int e0;
    e0 = error_count;
    check_ready(cpu_ready, 1'b1);
    access_check(1'b0, 32'h100, 32'h0, 0);
    access_check(1'b0, 32'h100, 32'h0, 1);   // Now resident
    report_test("reset_read", e0);
  endtask

  task automatic test_line_words();
    int e0;
    e0 = error_count;
    access_check(1'b1, 32'h044, 32'hcafe_0044, 0);   // Write allocate
    access_check(1'b0, 32'h040, 32'h0, 1);
    access_check(1'b0, 32'h044, 32'h0, 1);
    access_check(1'b0, 32'h048, 32'h0, 1);
    access_check(1'b0, 32'h04c, 32'h0, 1);
    report_test("line_words", e0);
  endtask

  // A, B and C all map to set 2
  task automatic test_lru();
    int e0;
    e0 = error_count;
    access_check(1'b0, 32'h020, 32'h0, 0);
    access_check(1'b0, 32'h0a0, 32'h0, 0);
    access_check(1'b0, 32'h020, 32'h0, 1);   // B becomes oldest
    access_check(1'b0, 32'h120, 32'h0, 0);   // Replaces B
    access_check(1'b0, 32'h020, 32'h0, 1);
    access_check(1'b0, 32'h0a0, 32'h0, 0);
    report_test("lru", e0);
  endtask

  // Set 5, writing C evicts dirty A and the reads bring each line back
  task automatic test_dirty_evict();
    int e0;
    e0 = error_count;
    access_check(1'b1, 32'h050, 32'h1111_aaaa, 0);
    access_check(1'b1, 32'h0d0, 32'h2222_bbbb, 0);
    access_check(1'b1, 32'h150, 32'h3333_cccc, 0);
    access_check(1'b0, 32'h050, 32'h0, 0);   // Back from the line memory
    access_check(1'b0, 32'h0d0, 32'h0, 0);
    access_check(1'b0, 32'h150, 32'h0, 0);
    check_ready(cpu_ready, 1'b1);
    report_test("dirty_evict", e0);
  endtask

  // 64 words, four tags over sets 0 to 3
  task automatic test_random();
    int          e0;
    logic [31:0] r;
    logic [5:0]  idx;
    logic [31:0] addr;
    e0 = error_count;
    for (int i = 0; i < 200; i++) begin
      r    = lcg_next();
      idx  = r[13:8];
      addr = {23'd0, idx[5:4], 1'b0, idx[3:2], idx[1:0], 2'b00};
      access_check(r[20], addr, lcg_next(), -1);
    end
    report_test("random", e0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the cache stopped answering", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_age[s][w]   = w;   // Way w starts at age w
        m_tag[s][w]   = '0;
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_read();
    test_line_words();
    test_lru();
    test_dirty_evict();
    test_random();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/l1_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1_dcache_macros.svh"

module l1_dcache_top (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    cpu_req_valid,
  input  wire l1_dcache_pkg::cpu_req_t cpu_req,
  output logic                         cpu_ready,
  output logic                         cpu_rsp_valid,
  output l1_dcache_pkg::cpu_rsp_t      cpu_rsp
);

  logic                    mem_req_valid;
  l1_dcache_pkg::mem_req_t mem_req;
  logic                    mem_ready;
  logic                    mem_rsp_valid;
  l1_dcache_pkg::mem_rsp_t mem_rsp;

  dcache_controller i_dcache_controller (
    .clk           (clk),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_ready     (cpu_ready),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp       (cpu_rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ready     (mem_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp)
  );

  line_memory #(
    .DEPTH_LINES (`DC_MEM_DEPTH_LINES),
    .LATENCY     (`DC_MEM_LATENCY)
  ) i_line_memory (
    .clk       (clk),
    .reset     (reset),
    .req_valid (mem_req_valid),
    .req       (mem_req),
    .ready     (mem_ready),
    .rsp_valid (mem_rsp_valid),
    .rsp       (mem_rsp)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1_dcache_macros.svh"

module dcache_controller (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    cpu_req_valid,
  input  wire l1_dcache_pkg::cpu_req_t cpu_req,
  output logic                         cpu_ready,
  output logic                         cpu_rsp_valid,
  output l1_dcache_pkg::cpu_rsp_t      cpu_rsp,
  output logic                         mem_req_valid,
  output l1_dcache_pkg::mem_req_t      mem_req,
  input  wire logic                    mem_ready,
  input  wire logic                    mem_rsp_valid,
  input  wire l1_dcache_pkg::mem_rsp_t mem_rsp
);

  localparam int NUM_SETS    = `DC_NUM_SETS;
  localparam int NUM_WAYS    = `DC_NUM_WAYS;
  localparam int OFFSET_BITS = `DC_OFFSET_BITS;
  localparam int SET_BITS    = `DC_SET_BITS;
  localparam int WAY_BITS    = `DC_WAY_BITS;
  localparam int LINE_BITS   = `DC_LINE_BYTES * 8;
  localparam int WORD_BITS   = $clog2(`DC_WORDS_PER_LINE);

  typedef enum logic [1:0] {IDLE, WRITEBACK, FILL} state_t;

  state_t state;
  logic   missed;   // Current access has gone through a miss
  logic   issued;   // Memory request of this phase already accepted

  logic                      hit;
  logic [WAY_BITS-1:0]       hit_way;
  logic [WAY_BITS-1:0]       victim_way;
  l1_dcache_pkg::tag_entry_t victim_entry;

  logic [LINE_BITS-1:0] data_q [NUM_SETS][NUM_WAYS];

  logic [SET_BITS-1:0]  set_idx;
  logic [WORD_BITS-1:0] word_idx;
  logic [LINE_BITS-1:0] hit_line;
  logic [31:0]          rd_word;
  logic                 access_hit;
  logic                 miss_start;
  logic                 fill_done;

  assign set_idx  = cpu_req.addr[OFFSET_BITS +: SET_BITS];
  assign word_idx = cpu_req.addr[2 +: WORD_BITS];

  dcache_tag_lookup i_tag_lookup (
    .clk          (clk),
    .reset        (reset),
    .addr         (cpu_req.addr),
    .touch        (access_hit),
    .fill         (fill_done),
    .mark_dirty   (access_hit && cpu_req.write),
    .fill_way     (victim_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_entry (victim_entry)
  );

  assign cpu_ready  = (state == IDLE);
  assign access_hit = cpu_ready && cpu_req_valid && hit;
  assign miss_start = cpu_ready && cpu_req_valid && !hit;
  assign fill_done  = (state == FILL) && mem_rsp_valid;

  // Same cycle answer on a hit
  assign hit_line      = data_q[set_idx][hit_way];
  assign rd_word       = hit_line[word_idx*32 +: 32];
  assign cpu_rsp_valid = access_hit;
  assign cpu_rsp       = '{rdata: cpu_req.write ? cpu_req.wdata : rd_word, hit: !missed};

  // Writeback goes to the victim's own address
  assign mem_req_valid = (state != IDLE) && !issued;
  assign mem_req = '{
    write:     (state == WRITEBACK),
    line_addr: (state == WRITEBACK) ? {victim_entry.tag, set_idx}
                                    : cpu_req.addr[31:OFFSET_BITS],
    wline:     data_q[set_idx][victim_way]
  };

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      missed <= 1'b0;
      issued <= 1'b0;
    end else begin
      if (mem_req_valid && mem_ready)
        issued <= 1'b1;
      case (state)
        IDLE: begin
          if (access_hit) begin
            missed <= 1'b0;
          end else if (miss_start) begin
            missed <= 1'b1;
            state  <= (victim_entry.valid && victim_entry.dirty) ? WRITEBACK : FILL;
          end
        end
        WRITEBACK: begin
          if (mem_rsp_valid) begin
            state  <= FILL;
            issued <= 1'b0;
          end
        end
        FILL: begin
          if (mem_rsp_valid) begin
            state  <= IDLE;   // Access retires as a hit next cycle
            issued <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word merge on a write hit and line install on a fill
  always_ff @(posedge clk) begin
    if (access_hit && cpu_req.write)
      data_q[set_idx][hit_way][word_idx*32 +: 32] <= cpu_req.wdata;
    if (fill_done)
      data_q[set_idx][victim_way] <= mem_rsp.rline;
  end

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    cpu_req_valid && !cpu_rsp_valid |=> cpu_req_valid && $stable(cpu_req))
    else $error("processor request dropped or changed before its response");

  a_rsp_in_miss: assert property (@(posedge clk) disable iff (reset)
    mem_rsp_valid |-> state != IDLE)
    else $error("memory response outside WRITEBACK or FILL");

endmodule

`default_nettype wire

//--- hdl/line_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1_dcache_macros.svh"

module line_memory #(
  parameter int DEPTH_LINES = 256,
  parameter int LATENCY     = 4
) (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    req_valid,
  input  wire l1_dcache_pkg::mem_req_t req,
  output logic                         ready,
  output logic                         rsp_valid,
  output l1_dcache_pkg::mem_rsp_t      rsp
);

  localparam int LINE_BITS = `DC_LINE_BYTES * 8;
  localparam int IDX_BITS  = $clog2(DEPTH_LINES);
  localparam int CNT_BITS  = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic [LINE_BITS-1:0] store [DEPTH_LINES] = '{default: '0};

  l1_dcache_pkg::mem_req_t req_q;
  logic                    busy;
  logic [CNT_BITS-1:0]     count;   // Cycles left until the response
  logic                    accept;
  logic [IDX_BITS-1:0]     idx;

  assign ready     = !busy;
  assign accept    = req_valid && ready;
  assign idx       = req_q.line_addr[IDX_BITS-1:0];
  assign rsp_valid = busy && (count == '0);
  assign rsp       = '{rline: store[idx]};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (accept) begin
      busy  <= 1'b1;
      count <= CNT_BITS'(LATENCY - 1);
    end else if (busy) begin
      if (count == '0)
        busy <= 1'b0;   // Response cycle ends the access
      else
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      req_q <= req;
    if (rsp_valid && req_q.write)
      store[idx] <= req_q.wline;
  end

  // Nothing else gets in until the response has gone out LATENCY cycles later
  a_busy_window: assert property (@(posedge clk) disable iff (reset)
    accept |=> (!accept && !rsp_valid) [*(LATENCY - 1)] ##1 (rsp_valid && !accept))
    else $error("line memory accepted a request while busy");

endmodule

`default_nettype wire

//--- hdl/dcache_tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "l1_dcache_macros.svh"

module dcache_tag_lookup (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic [31:0]             addr,
  input  wire logic                    touch,
  input  wire logic                    fill,
  input  wire logic                    mark_dirty,
  input  wire logic [`DC_WAY_BITS-1:0] fill_way,
  output logic                         hit,
  output logic [`DC_WAY_BITS-1:0]      hit_way,
  output logic [`DC_WAY_BITS-1:0]      victim_way,
  output l1_dcache_pkg::tag_entry_t    victim_entry
);

  localparam int NUM_SETS    = `DC_NUM_SETS;
  localparam int NUM_WAYS    = `DC_NUM_WAYS;
  localparam int OFFSET_BITS = `DC_OFFSET_BITS;
  localparam int SET_BITS    = `DC_SET_BITS;
  localparam int WAY_BITS    = `DC_WAY_BITS;
  localparam int TAG_BITS    = `DC_TAG_BITS;

  l1_dcache_pkg::tag_entry_t tags [NUM_SETS][NUM_WAYS];

  logic [SET_BITS-1:0] set_idx;
  logic [TAG_BITS-1:0] tag;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [WAY_BITS-1:0] hit_age;

  assign set_idx = addr[OFFSET_BITS +: SET_BITS];
  assign tag     = addr[31 -: TAG_BITS];
  assign hit_age = tags[set_idx][hit_way].age;

  // Parallel compare of every way in the set
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = tags[set_idx][w].valid && (tags[set_idx][w].tag == tag);
      if (hit_vec[w]) begin
        hit     = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
  end

  // Oldest way by default, lowest invalid way takes priority
  always_comb begin
    victim_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (tags[set_idx][w].age == WAY_BITS'(NUM_WAYS - 1))
        victim_way = WAY_BITS'(w);
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tags[set_idx][w].valid)
        victim_way = WAY_BITS'(w);
    end
    victim_entry = tags[set_idx][victim_way];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          tags[s][w] <= '{valid: 1'b0, dirty: 1'b0, age: WAY_BITS'(w), tag: '0};
        end
      end
    end else begin
      if (touch) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (tags[set_idx][w].age < hit_age)
            tags[set_idx][w].age <= tags[set_idx][w].age + 1'b1;
        end
        tags[set_idx][hit_way].age <= '0;   // Most recent
      end
      if (mark_dirty)
        tags[set_idx][hit_way].dirty <= 1'b1;
      if (fill) begin
        tags[set_idx][fill_way].valid <= 1'b1;
        tags[set_idx][fill_way].dirty <= 1'b0;
        tags[set_idx][fill_way].tag   <= tag;
      end
    end
  end

  // A line is only installed after a miss, so a tag never sits in two ways
  a_one_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec))
    else $error("more than one way hits in set %0d", set_idx);

endmodule

`default_nettype wire

//--- hdl/l1_dcache_pkg.sv
`default_nettype none
`include "l1_dcache_macros.svh"

package l1_dcache_pkg;

  // One word access from the processor
  typedef struct packed {
    logic        write;
    logic [31:0] addr;   // Byte address, word aligned
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        hit;    // Clear when the access went through a miss
  } cpu_rsp_t;

  // Line transfer to the backing store
  typedef struct packed {
    logic                            write;
    logic [31-`DC_OFFSET_BITS:0]     line_addr;  // Address without the offset bits
    logic [`DC_LINE_BYTES*8-1:0]     wline;
  } mem_req_t;

  typedef struct packed {
    logic [`DC_LINE_BYTES*8-1:0] rline;
  } mem_rsp_t;

  // Per way bookkeeping
  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    logic [`DC_WAY_BITS-1:0]  age;   // 0 is most recently used
    logic [`DC_TAG_BITS-1:0]  tag;
  } tag_entry_t;

endpackage

`default_nettype wire

//--- hdl/l1_dcache_macros.svh
`ifndef L1_DCACHE_MACROS_SVH
`define L1_DCACHE_MACROS_SVH

// Cache geometry
`define DC_LINE_BYTES      16
`define DC_NUM_SETS        8
`define DC_NUM_WAYS        2

// Backing store
`define DC_MEM_LATENCY     4    // Cycles from acceptance to response
`define DC_MEM_DEPTH_LINES 256

// Derived address split
`define DC_OFFSET_BITS     $clog2(`DC_LINE_BYTES)
`define DC_SET_BITS        $clog2(`DC_NUM_SETS)
`define DC_WAY_BITS        $clog2(`DC_NUM_WAYS)
`define DC_TAG_BITS        (32 - `DC_OFFSET_BITS - `DC_SET_BITS)

`define DC_WORDS_PER_LINE  (`DC_LINE_BYTES / 4)

`endif
